// File: hw/mem_pkg.sv
package mem_pkg;

  // data path and address width
  localparam int unsigned XLEN = 64;
  // one instruction, half a memory word
  localparam int unsigned INSTR_W = 32;
  // one strobe bit per byte lane
  localparam int unsigned STRB_W = XLEN / 8;

  // shared ram geometry
  localparam int unsigned RAM_WORDS = 256;
  localparam int unsigned RAM_IDX_W = 8;
  // word index starts above the byte offset, so offset width is this too
  localparam int unsigned RAM_IDX_LSB = 3;

  // fetch output credits, held in a small counter
  localparam int unsigned FETCH_CNT_W = 2;
  localparam logic [FETCH_CNT_W-1:0] FETCH_CREDITS = 2'd2;

  // load/store request queue, requester starts with this many credits
  localparam int unsigned LS_QUEUE_DEPTH = 2;
  localparam int unsigned LS_PTR_W = $clog2(LS_QUEUE_DEPTH);

  // last-grant bit after reset; set means fetch went last, so load/store wins first
  localparam logic ARB_LAST_FE_RST = 1'b1;

  // load/store opcode
  typedef enum logic {
    LS_LOAD,
    LS_STORE
  } ls_op_e;

  // access size
  typedef enum logic [1:0] {
    SZ_BYTE,
    SZ_HALF,
    SZ_WORD,
    SZ_DWORD
  } mem_size_e;

  // fetch fsm
  typedef enum logic [1:0] {
    FE_IDLE,
    FE_REQ,
    FE_WAIT
  } fetch_state_e;

  // lsu issue fsm
  typedef enum logic {
    LS_IDLE,
    LS_WAIT
  } lsu_state_e;

endpackage

// File: hw/shared_ram.sv
module shared_ram (
  input  logic                            clk,
  input  logic                            ram_en_i,
  input  logic                            ram_we_i,
  input  logic [mem_pkg::RAM_IDX_W-1:0]   ram_idx_i,
  input  logic [mem_pkg::STRB_W-1:0]      ram_strb_i,
  input  logic [mem_pkg::XLEN-1:0]        ram_wdata_i,
  output logic [mem_pkg::XLEN-1:0]        ram_rdata_o
);

  // word storage
  logic [mem_pkg::XLEN-1:0] mem_q [mem_pkg::RAM_WORDS];

  // write lanes under strobe at the granting edge
  always_ff @(posedge clk) begin
    if (ram_en_i && ram_we_i) begin
      for (int b = 0; b < mem_pkg::STRB_W; b++) begin
        if (ram_strb_i[b]) begin
          mem_q[ram_idx_i][b*8 +: 8] <= ram_wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // registered read, data valid one cycle after the enable
  // holds last value on idle and write cycles
  always_ff @(posedge clk) begin
    if (ram_en_i && !ram_we_i) begin
      ram_rdata_o <= mem_q[ram_idx_i];
    end
  end

endmodule

// File: hw/mem_arbiter.sv
module mem_arbiter (
  input  logic                            clk,
  input  logic                            rst_n_i,
  // fetch requester, read only
  input  logic                            fe_req_i,
  input  logic [mem_pkg::XLEN-1:0]        fe_addr_i,
  output logic                            fe_gnt_o,
  // load/store requester
  input  logic                            ls_req_i,
  input  logic [mem_pkg::XLEN-1:0]        ls_addr_i,
  input  logic                            ls_we_i,
  input  logic [mem_pkg::STRB_W-1:0]      ls_strb_i,
  input  logic [mem_pkg::XLEN-1:0]        ls_wdata_i,
  output logic                            ls_gnt_o,
  // ram command
  output logic                            ram_en_o,
  output logic                            ram_we_o,
  output logic [mem_pkg::RAM_IDX_W-1:0]   ram_idx_o,
  output logic [mem_pkg::STRB_W-1:0]      ram_strb_o,
  output logic [mem_pkg::XLEN-1:0]        ram_wdata_o
);

  // set when fetch won the most recent grant
  logic last_fe_q;

  // load/store wins when alone or when fetch went last
  assign ls_gnt_o = ls_req_i && (!fe_req_i || last_fe_q);
  // fetch takes whatever load/store leaves
  assign fe_gnt_o = fe_req_i && !ls_gnt_o;

  // round-robin history, only moves on an actual grant
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      last_fe_q <= mem_pkg::ARB_LAST_FE_RST;
    end else if (fe_gnt_o) begin
      last_fe_q <= 1'b1;
    end else if (ls_gnt_o) begin
      last_fe_q <= 1'b0;
    end
  end

  // steer winner to the ram
  assign ram_en_o = fe_gnt_o || ls_gnt_o;
  // fetch never writes
  assign ram_we_o = ls_gnt_o && ls_we_i;
  // word index from address bits above the byte offset
  assign ram_idx_o = ls_gnt_o ? ls_addr_i[mem_pkg::RAM_IDX_LSB +: mem_pkg::RAM_IDX_W]
                              : fe_addr_i[mem_pkg::RAM_IDX_LSB +: mem_pkg::RAM_IDX_W];
  // write payload only ever comes from load/store
  assign ram_strb_o  = ls_strb_i;
  assign ram_wdata_o = ls_wdata_i;

endmodule

// File: hw/fetch_unit.sv
module fetch_unit (
  input  logic                            clk,
  input  logic                            rst_n_i,
  input  logic                            redirect_i,
  input  logic [mem_pkg::XLEN-1:0]        redirect_pc_i,
  input  logic                            instr_credit_i,
  output logic                            fe_req_o,
  output logic [mem_pkg::XLEN-1:0]        fe_addr_o,
  input  logic                            fe_gnt_i,
  input  logic [mem_pkg::XLEN-1:0]        ram_rdata_i,
  output logic                            instr_valid_o,
  output logic [mem_pkg::INSTR_W-1:0]     instr_o,
  output logic [mem_pkg::XLEN-1:0]        instr_pc_o
);

  mem_pkg::fetch_state_e              state_q;
  mem_pkg::fetch_state_e              state_d;
  logic [mem_pkg::XLEN-1:0]           pc_q;
  logic [mem_pkg::XLEN-1:0]           target_pc;
  logic                               run_q;
  logic                               discard_q;
  logic [mem_pkg::FETCH_CNT_W-1:0]    credit_q;
  logic [mem_pkg::FETCH_CNT_W-1:0]    ret_ext;
  logic [mem_pkg::FETCH_CNT_W-1:0]    valid_ext;
  logic                               have_credit;
  logic                               spare_credit;
  logic                               take_data;
  logic                               instr_valid_q;
  logic [mem_pkg::INSTR_W-1:0]        instr_sel;
  logic [mem_pkg::INSTR_W-1:0]        instr_q;
  logic [mem_pkg::XLEN-1:0]           instr_pc_q;

  // instructions are 4-byte aligned
  assign target_pc = {redirect_pc_i[mem_pkg::XLEN-1:2], 2'b00};

  assign ret_ext   = {{(mem_pkg::FETCH_CNT_W-1){1'b0}}, instr_credit_i};
  assign valid_ext = {{(mem_pkg::FETCH_CNT_W-1){1'b0}}, instr_valid_q};
  // credit left after the one being presented this cycle
  assign have_credit = (credit_q - valid_ext) != '0;
  // at least two held, i.e. one remains beyond the word now arriving
  // valid pulse is never high in FE_WAIT
  assign spare_credit = |credit_q[mem_pkg::FETCH_CNT_W-1:1];

  // ram data is on the bus in FE_WAIT; drop it if stale or redirected now
  assign take_data = (state_q == mem_pkg::FE_WAIT) && !discard_q && !redirect_i;

  // pc bit 2 picks the upper half
  assign instr_sel = pc_q[2] ? ram_rdata_i[mem_pkg::XLEN-1:mem_pkg::INSTR_W]
                             : ram_rdata_i[mem_pkg::INSTR_W-1:0];

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      mem_pkg::FE_IDLE: begin
        // wait for first redirect and a free credit
        if ((run_q || redirect_i) && have_credit) begin
          state_d = mem_pkg::FE_REQ;
        end
      end
      mem_pkg::FE_REQ: begin
        // request held until granted
        if (fe_gnt_i) begin
          state_d = mem_pkg::FE_WAIT;
        end
      end
      mem_pkg::FE_WAIT: begin
        // back to back only when another credit is already in hand
        state_d = (take_data && spare_credit) ? mem_pkg::FE_REQ : mem_pkg::FE_IDLE;
      end
      default: state_d = mem_pkg::FE_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q       <= mem_pkg::FE_IDLE;
      pc_q          <= '0;
      run_q         <= 1'b0;
      discard_q     <= 1'b0;
      credit_q      <= mem_pkg::FETCH_CREDITS;
      instr_valid_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      // returns in, presented instructions out
      credit_q      <= credit_q + ret_ext - valid_ext;
      instr_valid_q <= take_data;
      if (redirect_i) begin
        run_q <= 1'b1;
        pc_q  <= target_pc;
      end else if (take_data) begin
        pc_q  <= pc_q + 4;
      end
      // grant taken in the redirect cycle, its data belongs to the old stream
      if (redirect_i && (state_q == mem_pkg::FE_REQ) && fe_gnt_i) begin
        discard_q <= 1'b1;
      end else if (state_q == mem_pkg::FE_WAIT) begin
        discard_q <= 1'b0;
      end
    end
  end

  // output payload
  always_ff @(posedge clk) begin
    if (take_data) begin
      instr_q    <= instr_sel;
      instr_pc_q <= pc_q;
    end
  end

  assign fe_req_o      = (state_q == mem_pkg::FE_REQ);
  assign fe_addr_o     = pc_q;
  assign instr_valid_o = instr_valid_q;
  assign instr_o       = instr_q;
  assign instr_pc_o    = instr_pc_q;

endmodule

// File: hw/lsu.sv
module lsu (
  input  logic                            clk,
  input  logic                            rst_n_i,
  // request side, credit based
  input  logic                            ls_req_valid_i,
  input  mem_pkg::ls_op_e                 ls_op_i,
  input  mem_pkg::mem_size_e              ls_size_i,
  input  logic [mem_pkg::XLEN-1:0]        ls_addr_i,
  input  logic [mem_pkg::XLEN-1:0]        ls_wdata_i,
  output logic                            ls_credit_o,
  // response side, no back-pressure
  output logic                            ls_resp_valid_o,
  output logic [mem_pkg::XLEN-1:0]        ls_rdata_o,
  // memory requester port
  output logic                            mem_req_o,
  output logic [mem_pkg::XLEN-1:0]        mem_addr_o,
  output logic                            mem_we_o,
  output logic [mem_pkg::STRB_W-1:0]      mem_strb_o,
  output logic [mem_pkg::XLEN-1:0]        mem_wdata_o,
  input  logic                            mem_gnt_i,
  input  logic [mem_pkg::XLEN-1:0]        ram_rdata_i
);

  // request queue storage
  mem_pkg::ls_op_e                    q_op    [mem_pkg::LS_QUEUE_DEPTH];
  mem_pkg::mem_size_e                 q_size  [mem_pkg::LS_QUEUE_DEPTH];
  logic [mem_pkg::XLEN-1:0]           q_addr  [mem_pkg::LS_QUEUE_DEPTH];
  logic [mem_pkg::XLEN-1:0]           q_wdata [mem_pkg::LS_QUEUE_DEPTH];
  logic [mem_pkg::LS_PTR_W-1:0]       wr_ptr_q;
  logic [mem_pkg::LS_PTR_W-1:0]       rd_ptr_q;
  logic [mem_pkg::LS_PTR_W:0]         count_q;
  mem_pkg::lsu_state_e                state_q;
  // head entry
  mem_pkg::ls_op_e                    head_op;
  mem_pkg::mem_size_e                 head_size;
  logic [mem_pkg::XLEN-1:0]           head_addr;
  logic [mem_pkg::XLEN-1:0]           head_wdata;
  logic [mem_pkg::RAM_IDX_LSB-1:0]    offs;
  logic [mem_pkg::RAM_IDX_LSB+2:0]    shamt;
  logic [mem_pkg::STRB_W-1:0]         lanes;
  logic [mem_pkg::XLEN-1:0]           load_mask;
  logic [mem_pkg::XLEN-1:0]           load_shifted;
  logic                               pop;

  assign head_op    = q_op[rd_ptr_q];
  assign head_size  = q_size[rd_ptr_q];
  assign head_addr  = q_addr[rd_ptr_q];
  assign head_wdata = q_wdata[rd_ptr_q];

  // byte offset in the word, and the same in bits
  assign offs  = head_addr[mem_pkg::RAM_IDX_LSB-1:0];
  assign shamt = {offs, 3'b000};

  // lanes covered by the access at offset 0
  always_comb begin
    unique case (head_size)
      mem_pkg::SZ_BYTE:  lanes = 8'h01;
      mem_pkg::SZ_HALF:  lanes = 8'h03;
      mem_pkg::SZ_WORD:  lanes = 8'h0f;
      default:           lanes = 8'hff;
    endcase
  end

  // widen lanes to a bit mask for load zero-extension
  always_comb begin
    for (int b = 0; b < mem_pkg::STRB_W; b++) begin
      load_mask[b*8 +: 8] = {8{lanes[b]}};
    end
  end

  // head entry goes out while idle and queue not empty
  assign mem_req_o   = (state_q == mem_pkg::LS_IDLE) && (count_q != '0);
  assign mem_addr_o  = head_addr;
  assign mem_we_o    = (head_op == mem_pkg::LS_STORE);
  // store lanes and data moved up to the offset
  assign mem_strb_o  = lanes << offs;
  assign mem_wdata_o = head_wdata << shamt;

  // load data arrives in LS_WAIT, moved down and trimmed to size
  assign load_shifted = ram_rdata_i >> shamt;

  // response, pop and credit return all in the same cycle
  assign pop             = (state_q == mem_pkg::LS_WAIT);
  assign ls_resp_valid_o = pop;
  assign ls_credit_o     = pop;
  // stores answer with zero
  assign ls_rdata_o = (head_op == mem_pkg::LS_LOAD) ? (load_shifted & load_mask) : '0;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      state_q  <= mem_pkg::LS_IDLE;
    end else begin
      // requester credits guarantee a free slot on push
      if (ls_req_valid_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + {{mem_pkg::LS_PTR_W{1'b0}}, ls_req_valid_i}
                         - {{mem_pkg::LS_PTR_W{1'b0}}, pop};
      // one access in flight, grant then one cycle for data
      unique case (state_q)
        mem_pkg::LS_IDLE: if (mem_gnt_i) state_q <= mem_pkg::LS_WAIT;
        default:          state_q <= mem_pkg::LS_IDLE;
      endcase
    end
  end

  // queue payload
  always_ff @(posedge clk) begin
    if (ls_req_valid_i) begin
      q_op[wr_ptr_q]    <= ls_op_i;
      q_size[wr_ptr_q]  <= ls_size_i;
      q_addr[wr_ptr_q]  <= ls_addr_i;
      q_wdata[wr_ptr_q] <= ls_wdata_i;
    end
  end

endmodule

// File: hw/mem_subsys_top.sv
module mem_subsys_top (
  input  logic                            clk,
  input  logic                            rst_n_i,
  // fetch control and instruction stream
  input  logic                            redirect_i,
  input  logic [mem_pkg::XLEN-1:0]        redirect_pc_i,
  input  logic                            instr_credit_i,
  output logic                            instr_valid_o,
  output logic [mem_pkg::INSTR_W-1:0]     instr_o,
  output logic [mem_pkg::XLEN-1:0]        instr_pc_o,
  // load/store requests and responses
  input  logic                            ls_req_valid_i,
  input  mem_pkg::ls_op_e                 ls_op_i,
  input  mem_pkg::mem_size_e              ls_size_i,
  input  logic [mem_pkg::XLEN-1:0]        ls_addr_i,
  input  logic [mem_pkg::XLEN-1:0]        ls_wdata_i,
  output logic                            ls_credit_o,
  output logic                            ls_resp_valid_o,
  output logic [mem_pkg::XLEN-1:0]        ls_rdata_o
);

  // fetch requester, port 0
  logic                            fe_req;
  logic [mem_pkg::XLEN-1:0]        fe_addr;
  logic                            fe_gnt;
  // load/store requester, port 1
  logic                            ls_req;
  logic [mem_pkg::XLEN-1:0]        ls_addr;
  logic                            ls_we;
  logic [mem_pkg::STRB_W-1:0]      ls_strb;
  logic [mem_pkg::XLEN-1:0]        ls_wdata;
  logic                            ls_gnt;
  // ram side
  logic                            ram_en;
  logic                            ram_we;
  logic [mem_pkg::RAM_IDX_W-1:0]   ram_idx;
  logic [mem_pkg::STRB_W-1:0]      ram_strb;
  logic [mem_pkg::XLEN-1:0]        ram_wdata;
  // read data goes to both requesters
  logic [mem_pkg::XLEN-1:0]        ram_rdata;

  fetch_unit u_fetch (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .redirect_i     (redirect_i),
    .redirect_pc_i  (redirect_pc_i),
    .instr_credit_i (instr_credit_i),
    .fe_req_o       (fe_req),
    .fe_addr_o      (fe_addr),
    .fe_gnt_i       (fe_gnt),
    .ram_rdata_i    (ram_rdata),
    .instr_valid_o  (instr_valid_o),
    .instr_o        (instr_o),
    .instr_pc_o     (instr_pc_o)
  );

  lsu u_lsu (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .ls_req_valid_i  (ls_req_valid_i),
    .ls_op_i         (ls_op_i),
    .ls_size_i       (ls_size_i),
    .ls_addr_i       (ls_addr_i),
    .ls_wdata_i      (ls_wdata_i),
    .ls_credit_o     (ls_credit_o),
    .ls_resp_valid_o (ls_resp_valid_o),
    .ls_rdata_o      (ls_rdata_o),
    .mem_req_o       (ls_req),
    .mem_addr_o      (ls_addr),
    .mem_we_o        (ls_we),
    .mem_strb_o      (ls_strb),
    .mem_wdata_o     (ls_wdata),
    .mem_gnt_i       (ls_gnt),
    .ram_rdata_i     (ram_rdata)
  );

  mem_arbiter u_arb (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .fe_req_i    (fe_req),
    .fe_addr_i   (fe_addr),
    .fe_gnt_o    (fe_gnt),
    .ls_req_i    (ls_req),
    .ls_addr_i   (ls_addr),
    .ls_we_i     (ls_we),
    .ls_strb_i   (ls_strb),
    .ls_wdata_i  (ls_wdata),
    .ls_gnt_o    (ls_gnt),
    .ram_en_o    (ram_en),
    .ram_we_o    (ram_we),
    .ram_idx_o   (ram_idx),
    .ram_strb_o  (ram_strb),
    .ram_wdata_o (ram_wdata)
  );

  shared_ram u_ram (
    .clk         (clk),
    .ram_en_i    (ram_en),
    .ram_we_i    (ram_we),
    .ram_idx_i   (ram_idx),
    .ram_strb_i  (ram_strb),
    .ram_wdata_i (ram_wdata),
    .ram_rdata_o (ram_rdata)
  );

endmodule

// File: verif/tb_clk_gen.sv
module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // free running clock, period 10
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // reset low for three rising edges, released just after the third
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

// File: verif/tb_top.sv
module tb_top;

  // run limit from six tests at a generous per-test budget
  localparam int NUM_TESTS   = 6;
  localparam int TEST_BUDGET = 500;
  localparam int MAX_CYCLES  = NUM_TESTS * TEST_BUDGET;
  // program image for the fetch tests
  localparam logic [63:0] PROG_BASE = 64'h100;
  localparam int          PROG_LEN  = 16;

  logic                       clk;
  logic                       rst_n;
  logic                       redirect_i;
  logic [63:0]                redirect_pc_i;
  logic                       instr_credit_i;
  logic                       instr_valid_o;
  logic [31:0]                instr_o;
  logic [63:0]                instr_pc_o;
  logic                       ls_req_valid_i;
  mem_pkg::ls_op_e            ls_op_i;
  mem_pkg::mem_size_e         ls_size_i;
  logic [63:0]                ls_addr_i;
  logic [63:0]                ls_wdata_i;
  logic                       ls_credit_o;
  logic                       ls_resp_valid_o;
  logic [63:0]                ls_rdata_o;

  // reference memory with one entry per ram word
  logic [63:0] ref_mem [256];
  logic [63:0] rng_q = 64'd60;
  // observed streams and expected load/store responses
  logic [31:0] fe_instr_q [$];
  logic [63:0] fe_pc_q [$];
  logic [63:0] resp_q [$];
  logic [63:0] exp_resp_q [$];
  int cycles = 0;
  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int test_err0 = 0;
  int ls_credits = mem_pkg::LS_QUEUE_DEPTH;
  int credit_pulses = 0;
  int credit_owed = 0;
  // fetch credits currently held by the dut
  int fe_credits = int'(mem_pkg::FETCH_CREDITS);
  bit auto_credit = 1'b0;

  tb_clk_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  mem_subsys_top u_dut (
    .clk             (clk),
    .rst_n_i         (rst_n),
    .redirect_i      (redirect_i),
    .redirect_pc_i   (redirect_pc_i),
    .instr_credit_i  (instr_credit_i),
    .instr_valid_o   (instr_valid_o),
    .instr_o         (instr_o),
    .instr_pc_o      (instr_pc_o),
    .ls_req_valid_i  (ls_req_valid_i),
    .ls_op_i         (ls_op_i),
    .ls_size_i       (ls_size_i),
    .ls_addr_i       (ls_addr_i),
    .ls_wdata_i      (ls_wdata_i),
    .ls_credit_o     (ls_credit_o),
    .ls_resp_valid_o (ls_resp_valid_o),
    .ls_rdata_o      (ls_rdata_o)
  );

  // outputs sampled on the falling edge between drive points
  always @(negedge clk) begin
    cycles++;
    if (rst_n) begin
      if (instr_valid_o) begin
        fe_instr_q.push_back(instr_o);
        fe_pc_q.push_back(instr_pc_o);
        fe_credits--;
        if (auto_credit) begin
          credit_owed++;
        end
      end
      if (ls_resp_valid_o) begin
        resp_q.push_back(ls_rdata_o);
      end
      if (ls_credit_o) begin
        ls_credits++;
        credit_pulses++;
      end
    end
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run went past %0d cycles without finishing", MAX_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  // hand back owed fetch credits one per cycle
  always @(posedge clk) begin
    #1;
    if (credit_owed > 0) begin
      instr_credit_i = 1'b1;
      credit_owed--;
      fe_credits++;
    end else begin
      instr_credit_i = 1'b0;
    end
  end

  function automatic logic [63:0] next_rand();
    rng_q = rng_q ^ (rng_q << 13);
    rng_q = rng_q ^ (rng_q >> 7);
    rng_q = rng_q ^ (rng_q << 17);
    return rng_q;
  endfunction

  function automatic int size_bytes(input mem_pkg::mem_size_e size);
    case (size)
      mem_pkg::SZ_BYTE: return 1;
      mem_pkg::SZ_HALF: return 2;
      mem_pkg::SZ_WORD: return 4;
      default:          return 8;
    endcase
  endfunction

  // field at the byte offset with zeros above the size
  function automatic logic [63:0] model_load(input logic [63:0] addr,
                                             input mem_pkg::mem_size_e size);
    logic [63:0] v;
    v = ref_mem[addr[10:3]] >> (8 * addr[2:0]);
    for (int b = size_bytes(size); b < 8; b++) begin
      v[b*8 +: 8] = 8'h00;
    end
    return v;
  endfunction

  // merge the low bytes of data into lanes from the offset upward
  task automatic model_store(input logic [63:0] addr, input mem_pkg::mem_size_e size,
                             input logic [63:0] data);
    int lane;
    for (int b = 0; b < size_bytes(size); b++) begin
      lane = addr[2:0] + b;
      if (lane < 8) begin
        ref_mem[addr[10:3]][lane*8 +: 8] = data[b*8 +: 8];
      end
    end
  endtask

  // pc bit 2 picks the upper half of the word
  function automatic logic [31:0] model_instr(input logic [63:0] pc);
    return pc[2] ? ref_mem[pc[10:3]][63:32] : ref_mem[pc[10:3]][31:0];
  endfunction

  task automatic check(input string name, input logic [63:0] act, input logic [63:0] exp);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, act, exp);
    end
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  // one request sent only while a credit is held
  task automatic ls_send(input mem_pkg::ls_op_e op, input mem_pkg::mem_size_e size,
                         input logic [63:0] addr, input logic [63:0] data);
    while (ls_credits == 0) begin
      ls_req_valid_i = 1'b0;
      step();
    end
    ls_req_valid_i = 1'b1;
    ls_op_i        = op;
    ls_size_i      = size;
    ls_addr_i      = addr;
    ls_wdata_i     = data;
    ls_credits--;
    if (op == mem_pkg::LS_STORE) begin
      model_store(addr, size, data);
      exp_resp_q.push_back(64'd0);
    end else begin
      exp_resp_q.push_back(model_load(addr, size));
    end
    step();
    ls_req_valid_i = 1'b0;
  endtask

  // wait for every response and compare in order
  task automatic ls_drain();
    while (resp_q.size() < exp_resp_q.size()) step();
    while (exp_resp_q.size() > 0) begin
      check("ls_rdata_o", resp_q.pop_front(), exp_resp_q.pop_front());
    end
  endtask

  // the old stream may still present in the redirect cycle so flush after it
  task automatic do_redirect(input logic [63:0] pc);
    redirect_i    = 1'b1;
    redirect_pc_i = pc;
    step();
    redirect_i = 1'b0;
    fe_instr_q.delete();
    fe_pc_q.delete();
  endtask

  task automatic fetch_expect(input logic [63:0] start_pc, input int n);
    logic [63:0] pc;
    while (fe_pc_q.size() < n) step();
    for (int i = 0; i < n; i++) begin
      pc = start_pc + 64'(4 * i);
      check("instr_pc_o", fe_pc_q.pop_front(), pc);
      check("instr_o", {32'd0, fe_instr_q.pop_front()}, {32'd0, model_instr(pc)});
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_err0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      $display("test %0d %s: %0d errors", tests_run, name, errors - test_err0);
    end
    test_err0 = errors;
  endtask

  task automatic test_dword_round_trip();
    for (int i = 0; i < 6; i++) begin
      ls_send(mem_pkg::LS_STORE, mem_pkg::SZ_DWORD, 64'h200 + 64'(8 * i), next_rand());
    end
    for (int i = 0; i < 6; i++) begin
      ls_send(mem_pkg::LS_LOAD, mem_pkg::SZ_DWORD, 64'h200 + 64'(8 * i), 64'd0);
    end
    ls_drain();
    end_test("dword round trip");
  endtask

  task automatic test_sized_access();
    logic [63:0] base;
    base = 64'h300;
    ls_send(mem_pkg::LS_STORE, mem_pkg::SZ_DWORD, base, next_rand());
    ls_send(mem_pkg::LS_STORE, mem_pkg::SZ_WORD, base, next_rand());
    ls_send(mem_pkg::LS_STORE, mem_pkg::SZ_BYTE, base + 3, next_rand());
    ls_send(mem_pkg::LS_STORE, mem_pkg::SZ_HALF, base + 6, next_rand());
    ls_send(mem_pkg::LS_STORE, mem_pkg::SZ_BYTE, base + 5, next_rand());
    // whole word after lane merging
    ls_send(mem_pkg::LS_LOAD, mem_pkg::SZ_DWORD, base, 64'd0);
    ls_send(mem_pkg::LS_LOAD, mem_pkg::SZ_BYTE, base + 3, 64'd0);
    ls_send(mem_pkg::LS_LOAD, mem_pkg::SZ_BYTE, base + 5, 64'd0);
    ls_send(mem_pkg::LS_LOAD, mem_pkg::SZ_HALF, base + 6, 64'd0);
    ls_send(mem_pkg::LS_LOAD, mem_pkg::SZ_HALF, base + 2, 64'd0);
    ls_send(mem_pkg::LS_LOAD, mem_pkg::SZ_WORD, base + 4, 64'd0);
    ls_send(mem_pkg::LS_LOAD, mem_pkg::SZ_WORD, base, 64'd0);
    ls_drain();
    end_test("sized stores and loads");
  endtask

  task automatic test_fetch_program();
    // two instructions per dword
    for (int i = 0; i < PROG_LEN / 2; i++) begin
      ls_send(mem_pkg::LS_STORE, mem_pkg::SZ_DWORD, PROG_BASE + 64'(8 * i), next_rand());
    end
    ls_drain();
    // fetch stays idle until the first redirect
    check("instr_valid_o count", 64'(fe_pc_q.size()), 64'd0);
    auto_credit = 1'b1;
    do_redirect(PROG_BASE);
    fetch_expect(PROG_BASE, PROG_LEN);
    end_test("fetch program");
  endtask

  task automatic test_back_pressure();
    // let the running stream use up every credit
    auto_credit = 1'b0;
    while (credit_owed != 0 || fe_credits != 0) step();
    do_redirect(PROG_BASE);
    credit_owed += int'(mem_pkg::FETCH_CREDITS);
    while (fe_pc_q.size() < int'(mem_pkg::FETCH_CREDITS)) step();
    repeat (30) step();
    if (fe_pc_q.size() != int'(mem_pkg::FETCH_CREDITS)) begin
      errors++;
      $display("%0d instructions arrived while only %0d credits were given",
               fe_pc_q.size(), mem_pkg::FETCH_CREDITS);
    end
    fetch_expect(PROG_BASE, int'(mem_pkg::FETCH_CREDITS));
    fe_instr_q.delete();
    fe_pc_q.delete();
    // returned credits pick up at the next pc
    auto_credit = 1'b1;
    credit_owed += int'(mem_pkg::FETCH_CREDITS);
    fetch_expect(PROG_BASE + 64'(4 * mem_pkg::FETCH_CREDITS), 4);
    end_test("credit back-pressure");
  endtask

  task automatic test_contention();
    int sent;
    credit_pulses = 0;
    sent = 0;
    fork
      begin
        for (int i = 0; i < 8; i++) begin
          ls_send(mem_pkg::LS_STORE, mem_pkg::SZ_DWORD, 64'h400 + 64'(8 * i), next_rand());
          sent++;
        end
        for (int i = 0; i < 8; i++) begin
          ls_send(mem_pkg::LS_LOAD, mem_pkg::SZ_DWORD, 64'h400 + 64'(8 * i), 64'd0);
          sent++;
        end
        ls_send(mem_pkg::LS_STORE, mem_pkg::SZ_HALF, 64'h402, next_rand());
        ls_send(mem_pkg::LS_LOAD, mem_pkg::SZ_WORD, 64'h400, 64'd0);
        sent += 2;
        ls_drain();
      end
      begin
        do_redirect(PROG_BASE);
        fetch_expect(PROG_BASE, PROG_LEN);
      end
    join
    check("ls_credit_o pulses", 64'(credit_pulses), 64'(sent));
    end_test("contention");
  endtask

  task automatic test_redirect_mid_stream();
    fe_instr_q.delete();
    fe_pc_q.delete();
    // stream still flowing from the last test
    while (fe_pc_q.size() < 3) step();
    do_redirect(PROG_BASE + 64'h20);
    fetch_expect(PROG_BASE + 64'h20, 8);
    end_test("redirect mid-stream");
  endtask

  initial begin
    redirect_i     = 1'b0;
    redirect_pc_i  = '0;
    instr_credit_i = 1'b0;
    ls_req_valid_i = 1'b0;
    ls_op_i        = mem_pkg::LS_LOAD;
    ls_size_i      = mem_pkg::SZ_DWORD;
    ls_addr_i      = '0;
    ls_wdata_i     = '0;
    wait (rst_n === 1'b1);
    step();
    // quiet outputs straight after reset
    check("instr_valid_o", {63'd0, instr_valid_o}, 64'd0);
    check("ls_resp_valid_o", {63'd0, ls_resp_valid_o}, 64'd0);
    check("ls_credit_o", {63'd0, ls_credit_o}, 64'd0);
    test_dword_round_trip();
    test_sized_access();
    test_fetch_program();
    test_back_pressure();
    test_contention();
    test_redirect_mid_stream();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
hw/mem_pkg.sv
hw/shared_ram.sv
hw/mem_arbiter.sv
hw/fetch_unit.sv
hw/lsu.sv
hw/mem_subsys_top.sv
verif/tb_clk_gen.sv
verif/tb_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal \
  --top-module tb_top \
  -f files.f \
  -o sim_tb

./obj_dir/sim_tb | tee "$LOG"

if grep -qx "Result: PASSED" "$LOG"; then
  echo "simulation run ok"
  exit 0
else
  echo "simulation run reported errors, see $LOG"
  exit 1
fi
